// File: Bender.yml
package:
  name: dual_core_lockstep

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_isa_pkg.sv
      - verilog/core_bus_pkg.sv
      - verilog/core_port_ifs.sv
      - verilog/fetch_core.sv
      - verilog/shadow_reset_ctrl.sv
      - verilog/input_delay_line.sv
      - verilog/output_delay_line.sv
      - verilog/output_comparator.sv
      - verilog/lockstep_top.sv
  - target: test
    files:
      - tests/tb_lockstep.sv

// File: dual_core_lockstep.f
+incdir+verilog
verilog/core_isa_pkg.sv
verilog/core_bus_pkg.sv
verilog/core_port_ifs.sv
verilog/fetch_core.sv
verilog/shadow_reset_ctrl.sv
verilog/input_delay_line.sv
verilog/output_delay_line.sv
verilog/output_comparator.sv
verilog/lockstep_top.sv
tests/tb_lockstep.sv

// File: tests/tb_lockstep.sv
`timescale 1ns/100ps
`include "lockstep_cfg.svh"

module tb_lockstep;

  localparam logic [31:0] boot_addr = 32'h0000_1000;
  localparam int prog_len = 64;
  // Cycle budgets per test including reset
  localparam int bud_clean = 140;
  localparam int bud_store = 100;
  localparam int bud_early = 60;
  localparam int bud_err   = 60;
  localparam int bud_pause = 100;

  logic        clk_i;
  logic        rst_ni;
  logic        fetch_enable;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_rdata;
  logic        instr_err;
  logic        instr_req;
  logic        alert_int;
  logic        alert_bus;

  // Main core model and its fault injection
  logic [31:0] pc_q;
  logic [31:0] acc_q;
  logic        waiting_q;
  logic        data_req_q;
  logic [31:0] data_addr_q;
  logic [31:0] data_wdata_q;
  logic [31:0] addr_flip;
  logic [31:0] wdata_flip;
  logic        corrupt_store;
  int          err_idx;
  int          retired;
  int          store_edge;
  int          err_edge;

  logic [31:0] prog [prog_len];
  int          cyc;
  int          check_errs;
  int          other_errs;

  lockstep_top dut (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .boot_addr_i            (boot_addr),
    .fetch_enable_i         (fetch_enable),
    .instr_req_i            (instr_req),
    .instr_addr_i           (pc_q ^ addr_flip),
    .instr_gnt_i            (instr_gnt),
    .instr_rvalid_i         (instr_rvalid),
    .instr_rdata_i          (instr_rdata),
    .instr_err_i            (instr_err),
    .data_req_i             (data_req_q),
    .data_addr_i            (data_addr_q),
    .data_wdata_i           (data_wdata_q ^ wdata_flip),
    .alert_major_internal_o (alert_int),
    .alert_major_bus_o      (alert_bus)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic int word_idx(input logic [31:0] pc);
    return int'((pc - boot_addr) >> 2) % prog_len;
  endfunction

  // Sum of the sign-extended add immediates in the first n words
  function automatic logic [31:0] acc_before(input int n);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < n; i++) begin
      if (!prog[i][31]) begin
        sum = sum + {prog[i][30], prog[i][30:0]};
      end
    end
    return sum;
  endfunction

  ////////////////////
  // Main core model and bus responder
  ////////////////////

  assign instr_req = fetch_enable & ~waiting_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q         <= boot_addr;
      acc_q        <= '0;
      waiting_q    <= 1'b0;
      data_req_q   <= 1'b0;
      data_addr_q  <= '0;
      data_wdata_q <= '0;
      wdata_flip   <= '0;
      instr_rvalid <= 1'b0;
      instr_rdata  <= '0;
      instr_err    <= 1'b0;
      retired      <= 0;
      store_edge   <= 0;
      err_edge     <= 0;
    end else begin
      data_req_q   <= 1'b0;
      wdata_flip   <= '0;
      instr_rvalid <= 1'b0;
      instr_err    <= 1'b0;
      if (instr_req) begin
        // Grant at once, the word comes back next cycle
        waiting_q    <= 1'b1;
        instr_rvalid <= 1'b1;
        instr_rdata  <= prog[word_idx(pc_q)];
        instr_err    <= (word_idx(pc_q) == err_idx);
      end else if (waiting_q && instr_rvalid) begin
        waiting_q <= 1'b0;
        pc_q      <= pc_q + 32'd4;
        retired   <= retired + 1;
        if (instr_err) begin
          err_edge <= cyc + 1;
        end else if (!instr_rdata[31]) begin
          acc_q <= acc_q + {instr_rdata[30], instr_rdata[30:0]};
        end else begin
          data_req_q   <= 1'b1;
          data_addr_q  <= {14'b0, instr_rdata[15:0], 2'b00};
          data_wdata_q <= acc_q;
          if (corrupt_store && store_edge == 0) begin
            wdata_flip <= 32'h0000_0100;
            store_edge <= cyc + 2;
          end
        end
      end
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic report_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    check_errs++;
    $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
  endtask

  task automatic check_alerts(input logic exp_int, input logic exp_bus);
    if (alert_int !== exp_int) begin
      report_value("alert_major_internal_o", exp_int, alert_int);
    end
    if (alert_bus !== exp_bus) begin
      report_value("alert_major_bus_o", exp_bus, alert_bus);
    end
  endtask

  // Main address may be corrupted in the last cycles of reset
  task automatic apply_reset(input logic [31:0] flip);
    @(posedge clk_i);
    rst_ni        <= 1'b0;
    fetch_enable  <= 1'b0;
    corrupt_store <= 1'b0;
    err_idx       <= -1;
    addr_flip     <= '0;
    repeat (16 - `LOCKSTEP_OFFSET) @(posedge clk_i);
    addr_flip <= flip;
    repeat (`LOCKSTEP_OFFSET) @(posedge clk_i);
    addr_flip    <= '0;
    rst_ni       <= 1'b1;
    fetch_enable <= 1'b1;
  endtask

  task automatic run_until_retired(input int count, input int budget);
    int n;
    n = 0;
    while (retired < count && n < budget) begin
      @(negedge clk_i);
      check_alerts(1'b0, 1'b0);
      n++;
    end
    if (retired < count) begin
      other_errs++;
      $display("Only %0d of %0d instructions retired in %0d cycles", retired, count, budget);
    end
    repeat (`LOCKSTEP_OFFSET + 2) begin
      @(negedge clk_i);
      check_alerts(1'b0, 1'b0);
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic clean_run();
    apply_reset('0);
    run_until_retired(40, bud_clean);
  endtask

  task automatic store_corruption();
    int n;
    n = 0;
    apply_reset('0);
    corrupt_store <= 1'b1;
    while ((store_edge == 0 || cyc < store_edge + `LOCKSTEP_OFFSET + 4) && n < bud_store) begin
      @(negedge clk_i);
      check_alerts(store_edge != 0 && cyc == store_edge + `LOCKSTEP_OFFSET, 1'b0);
      n++;
    end
    if (store_edge == 0) begin
      other_errs++;
      $display("No store was executed in the corruption test");
    end
  endtask

  task automatic early_addr_glitch();
    apply_reset(32'h0000_0040);
    run_until_retired(8, bud_early);
  endtask

  task automatic bus_error();
    int n;
    n = 0;
    apply_reset('0);
    err_idx <= 5;
    while ((err_edge == 0 || cyc < err_edge + `LOCKSTEP_OFFSET + 6) && n < bud_err) begin
      @(negedge clk_i);
      check_alerts(1'b0, err_edge != 0 && cyc >= err_edge + `LOCKSTEP_OFFSET);
      n++;
    end
    if (err_edge == 0) begin
      other_errs++;
      $display("The bus error word was never returned");
    end
  endtask

  task automatic fetch_pause();
    int   n;
    logic found;
    n = 0;
    found = 1'b0;
    apply_reset('0);
    run_until_retired(6, bud_pause);
    @(posedge clk_i);
    fetch_enable <= 1'b0;
    repeat (10) begin
      @(negedge clk_i);
      check_alerts(1'b0, 1'b0);
    end
    @(posedge clk_i);
    fetch_enable <= 1'b1;
    while (!found && n < bud_pause) begin
      @(negedge clk_i);
      check_alerts(1'b0, 1'b0);
      found = data_req_q;
      n++;
    end
    if (!found) begin
      other_errs++;
      $display("No store followed the fetch pause");
    end else if ((data_wdata_q ^ wdata_flip) !== acc_before(retired - 1)) begin
      report_value("data_wdata_i", acc_before(retired - 1), data_wdata_q ^ wdata_flip);
    end
    run_until_retired(retired + 1, bud_pause);
  endtask

  initial begin
    logic [31:0] rnd;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    fetch_enable  = 1'b0;
    instr_gnt     = 1'b1;
    addr_flip     = '0;
    corrupt_store = 1'b0;
    err_idx       = -1;
    pc_q          = boot_addr;
    waiting_q     = 1'b0;
    data_req_q    = 1'b0;
    data_addr_q   = '0;
    data_wdata_q  = '0;
    wdata_flip    = '0;
    instr_rvalid  = 1'b0;
    instr_rdata   = '0;
    instr_err     = 1'b0;
    cyc           = 0;
    check_errs    = 0;
    other_errs    = 0;
    // Every fourth word stores, the rest add random immediates
    rnd = 32'd60;
    for (int i = 0; i < prog_len; i++) begin
      rnd = xorshift32(rnd);
      if (i % 4 == 3) begin
        prog[i] = {1'b1, 15'b0, rnd[15:0]};
      end else begin
        prog[i] = {1'b0, rnd[30:0]};
      end
    end
    clean_run();
    store_corruption();
    early_addr_glitch();
    bus_error();
    fetch_pause();
    $display("%0d value errors, %0d other errors", check_errs, other_errs);
    if (check_errs == 0 && other_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Twice the summed test budgets
  initial begin
    #(2 * (bud_clean + bud_store + bud_early + bud_err + bud_pause) * 20);
    $display("Timeout, the tests did not complete in time");
    $display("%0d value errors, %0d other errors", check_errs, other_errs + 1);
    $display("sim failed");
    $finish;
  end

endmodule

// File: verilog/core_bus_pkg.sv
`include "lockstep_cfg.svh"

package core_bus_pkg;

  // Addresses and data on both buses
  typedef logic [`CORE_XLEN-1:0] word_t;

  // Every core output that takes part in the comparison
  typedef struct packed {
    logic  instr_req;
    word_t instr_addr;
    logic  data_req;
    word_t data_addr;
    word_t data_wdata;
  } core_out_t;

endpackage

// File: verilog/core_isa_pkg.sv
`include "lockstep_cfg.svh"

package core_isa_pkg;

  typedef enum logic {
    opc_add   = 1'b0,
    opc_store = 1'b1
  } opcode_e;

  // Accumulate a signed immediate
  typedef struct packed {
    opcode_e                    op;
    logic signed [`CORE_XLEN-2:0] imm;
  } add_instr_t;

  // Store the accumulator to a word address
  typedef struct packed {
    opcode_e                                  op;
    logic [`CORE_XLEN-2-`STORE_ADDR_W:0]      unused;
    logic [`STORE_ADDR_W-1:0]                 addr;
  } store_instr_t;

  // One fetched word with two decodings selected by op
  typedef union packed {
    add_instr_t   add;
    store_instr_t store;
  } instr_u;

endpackage

// File: verilog/core_port_ifs.sv
`timescale 1ns/100ps

// Bus inputs seen by a core
interface core_in_if;

  logic                fetch_enable;
  logic                instr_gnt;
  logic                instr_rvalid;
  core_bus_pkg::word_t instr_rdata;
  logic                instr_err;

  // Read by the delay line from the top level
  modport src (
    input fetch_enable, instr_gnt, instr_rvalid, instr_rdata, instr_err
  );

  // Driven by the delay line towards the shadow core
  modport dly (
    output fetch_enable, instr_gnt, instr_rvalid, instr_rdata, instr_err
  );

  modport core (
    input fetch_enable, instr_gnt, instr_rvalid, instr_rdata, instr_err
  );

endinterface

// Outputs of a core, as compared by the checker
interface core_out_if;

  logic                instr_req;
  core_bus_pkg::word_t instr_addr;
  logic                data_req;
  core_bus_pkg::word_t data_addr;
  core_bus_pkg::word_t data_wdata;

  modport drv (output instr_req, instr_addr, data_req, data_addr, data_wdata);
  modport mon (input instr_req, instr_addr, data_req, data_addr, data_wdata);

endinterface

// File: verilog/fetch_core.sv
`timescale 1ns/100ps
`include "lockstep_cfg.svh"

module fetch_core (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  core_bus_pkg::word_t boot_addr_i,
  core_in_if.core             in_if,
  core_out_if.drv             out_if,
  output logic                alert_bus_o
);

  core_bus_pkg::word_t  pc_q;
  core_bus_pkg::word_t  acc_q;
  logic                 waiting_q;
  logic                 data_req_q;
  core_bus_pkg::word_t  data_addr_q;
  core_bus_pkg::word_t  data_wdata_q;
  logic                 err_q;

  logic                 fetch_req;
  logic                 fetch_done;
  logic                 word_ret;
  core_isa_pkg::instr_u instr;
  core_bus_pkg::word_t  imm_ext;
  core_bus_pkg::word_t  store_addr;

  ////////////////////
  // Fetch handshake
  ////////////////////

  // One fetch in flight at a time
  assign fetch_req  = in_if.fetch_enable & ~waiting_q;
  assign fetch_done = fetch_req & in_if.instr_gnt;
  assign word_ret   = waiting_q & in_if.instr_rvalid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q      <= boot_addr_i;
      waiting_q <= 1'b0;
    end else if (fetch_done) begin
      waiting_q <= 1'b1;
    end else if (word_ret) begin
      waiting_q <= 1'b0;
      pc_q      <= pc_q + core_bus_pkg::word_t'(4);
    end
  end

  ////////////////////
  // Execute
  ////////////////////

  assign instr      = core_isa_pkg::instr_u'(in_if.instr_rdata);
  assign imm_ext    = {instr.add.imm[`CORE_XLEN-2], instr.add.imm};
  assign store_addr = core_bus_pkg::word_t'(instr.store.addr) << `STORE_ADDR_SHIFT;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q        <= '0;
      data_req_q   <= 1'b0;
      data_addr_q  <= '0;
      data_wdata_q <= '0;
      err_q        <= 1'b0;
    end else begin
      data_req_q <= 1'b0;
      if (word_ret) begin
        // A faulty word is dropped, the error stays until reset
        if (in_if.instr_err) begin
          err_q <= 1'b1;
        end else if (instr.add.op == core_isa_pkg::opc_add) begin
          acc_q <= acc_q + imm_ext;
        end else begin
          data_req_q   <= 1'b1;
          data_addr_q  <= store_addr;
          data_wdata_q <= acc_q;
        end
      end
    end
  end

  assign out_if.instr_req  = fetch_req;
  assign out_if.instr_addr = pc_q;
  assign out_if.data_req   = data_req_q;
  assign out_if.data_addr  = data_addr_q;
  assign out_if.data_wdata = data_wdata_q;
  assign alert_bus_o       = err_q;

endmodule

// File: verilog/input_delay_line.sv
`timescale 1ns/100ps
`include "lockstep_cfg.svh"

module input_delay_line (
  input  logic    clk_i,
  input  logic    rst_ni,
  core_in_if.src  src_if,
  core_in_if.dly  dly_if
);

  typedef struct packed {
    logic                fetch_enable;
    logic                instr_gnt;
    logic                instr_rvalid;
    core_bus_pkg::word_t instr_rdata;
    logic                instr_err;
  } in_bundle_t;

  in_bundle_t                        stage_in;
  in_bundle_t [`LOCKSTEP_OFFSET-1:0] stage_q;

  assign stage_in = '{
    fetch_enable: src_if.fetch_enable,
    instr_gnt:    src_if.instr_gnt,
    instr_rvalid: src_if.instr_rvalid,
    instr_rdata:  src_if.instr_rdata,
    instr_err:    src_if.instr_err
  };

  // New sample enters at the top, stage 0 feeds the shadow core
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      for (int unsigned i = 0; i < `LOCKSTEP_OFFSET - 1; i++) begin
        stage_q[i] <= stage_q[i+1];
      end
      stage_q[`LOCKSTEP_OFFSET-1] <= stage_in;
    end
  end

  assign dly_if.fetch_enable = stage_q[0].fetch_enable;
  assign dly_if.instr_gnt    = stage_q[0].instr_gnt;
  assign dly_if.instr_rvalid = stage_q[0].instr_rvalid;
  assign dly_if.instr_rdata  = stage_q[0].instr_rdata;
  assign dly_if.instr_err    = stage_q[0].instr_err;

endmodule

// File: verilog/lockstep_cfg.svh
`ifndef LOCKSTEP_CFG_SVH
`define LOCKSTEP_CFG_SVH

// Cycles by which the shadow core trails the main core (two or more)
`define LOCKSTEP_OFFSET 2

// Width of instruction and data words
`define CORE_XLEN 32

// Word address field carried by a store
`define STORE_ADDR_W 16
// Word address to byte address
`define STORE_ADDR_SHIFT 2

`endif

// File: verilog/lockstep_top.sv
`timescale 1ns/100ps

module lockstep_top (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  core_bus_pkg::word_t boot_addr_i,
  input  logic                fetch_enable_i,

  input  logic                instr_req_i,
  input  core_bus_pkg::word_t instr_addr_i,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  core_bus_pkg::word_t instr_rdata_i,
  input  logic                instr_err_i,

  // Main core data strobe
  input  logic                data_req_i,
  input  core_bus_pkg::word_t data_addr_i,
  input  core_bus_pkg::word_t data_wdata_i,

  output logic                alert_major_internal_o,
  output logic                alert_major_bus_o
);

  logic                    shadow_rst_n;
  logic                    cmp_en;
  core_bus_pkg::core_out_t main_out;
  core_bus_pkg::core_out_t main_dly;

  core_in_if  in_src ();
  core_in_if  in_dly ();
  core_out_if shadow_out ();

  assign in_src.fetch_enable = fetch_enable_i;
  assign in_src.instr_gnt    = instr_gnt_i;
  assign in_src.instr_rvalid = instr_rvalid_i;
  assign in_src.instr_rdata  = instr_rdata_i;
  assign in_src.instr_err    = instr_err_i;

  assign main_out = '{
    instr_req:  instr_req_i,
    instr_addr: instr_addr_i,
    data_req:   data_req_i,
    data_addr:  data_addr_i,
    data_wdata: data_wdata_i
  };

  shadow_reset_ctrl u_rst_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  input_delay_line u_in_dly (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .src_if (in_src.src),
    .dly_if (in_dly.dly)
  );

  // Shadow copy held in reset until the inputs have caught up
  fetch_core u_shadow_core (
    .clk_i       (clk_i),
    .rst_ni      (shadow_rst_n),
    .boot_addr_i (boot_addr_i),
    .in_if       (in_dly.core),
    .out_if      (shadow_out.drv),
    .alert_bus_o (alert_major_bus_o)
  );

  output_delay_line u_out_dly (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .main_i     (main_out),
    .main_dly_o (main_dly)
  );

  output_comparator u_cmp (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cmp_en_i   (cmp_en),
    .shadow_if  (shadow_out.mon),
    .main_dly_i (main_dly),
    .mismatch_o (alert_major_internal_o)
  );

endmodule

// File: verilog/output_comparator.sv
`timescale 1ns/100ps

module output_comparator (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cmp_en_i,
  core_out_if.mon                 shadow_if,
  input  core_bus_pkg::core_out_t main_dly_i,
  output logic                    mismatch_o
);

  core_bus_pkg::core_out_t shadow_d;
  core_bus_pkg::core_out_t shadow_q;

  assign shadow_d = '{
    instr_req:  shadow_if.instr_req,
    instr_addr: shadow_if.instr_addr,
    data_req:   shadow_if.data_req,
    data_addr:  shadow_if.data_addr,
    data_wdata: shadow_if.data_wdata
  };

  // Breaks the path from the shadow core into the compare
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else begin
      shadow_q <= shadow_d;
    end
  end

  // Any differing bit in any output is a major fault
  assign mismatch_o = cmp_en_i & (shadow_q != main_dly_i);

endmodule

// File: verilog/output_delay_line.sv
`timescale 1ns/100ps
`include "lockstep_cfg.svh"

module output_delay_line (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  core_bus_pkg::core_out_t main_i,
  output core_bus_pkg::core_out_t main_dly_o
);

  // One extra stage matches the registered shadow outputs
  localparam int unsigned depth = `LOCKSTEP_OFFSET + 1;

  core_bus_pkg::core_out_t [depth-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      for (int unsigned i = 0; i < depth - 1; i++) begin
        stage_q[i] <= stage_q[i+1];
      end
      stage_q[depth-1] <= main_i;
    end
  end

  // Oldest sample lines up with the shadow register
  assign main_dly_o = stage_q[0];

endmodule

// File: verilog/shadow_reset_ctrl.sv
`timescale 1ns/100ps
`include "lockstep_cfg.svh"

module shadow_reset_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  localparam int unsigned      cnt_w   = $clog2(`LOCKSTEP_OFFSET);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(`LOCKSTEP_OFFSET - 1);

  logic [cnt_w-1:0] cnt_q;
  logic             rst_set_q;
  logic             cmp_en_q;

  // Saturates once the offset has elapsed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_q != cnt_max) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Shadow core leaves reset first, comparison starts one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_set_q <= 1'b0;
      cmp_en_q  <= 1'b0;
    end else begin
      rst_set_q <= (cnt_q == cnt_max);
      cmp_en_q  <= rst_set_q;
    end
  end

  assign shadow_rst_no = rst_set_q;
  assign cmp_en_o      = cmp_en_q;

endmodule
